// ==== Bender.yml ====
package:
  name: piano_datapath

sources:
  - piano_pkg.sv
  - song_pkg.sv
  - key_debouncer.sv
  - note_capture.sv
  - beat_metronome.sv
  - tone_generator.sv
  - song_memory.sv
  - piano_datapath.sv
  - target: test
    files:
      - tb_piano_datapath.sv

// ==== beat_metronome.sv ====
/*
 120 BPM metronome, one beat is CLOCK_FREQ/2 cycles.
 CLOCK_FREQ must be at least 4. The beat count stops at 15.
*/
module beat_metronome #(
    parameter int CLOCK_FREQ = 50_000_000
) (
    input  logic       clock,
    input  logic       rst,
    input  logic       metro_clear,
    input  logic       metro_run,
    output logic       beat_pulse,
    output logic       half_beat,
    output logic [3:0] beats
);

    localparam int BEAT_CYCLES = CLOCK_FREQ / 2;
    localparam int CNT_W       = $clog2(BEAT_CYCLES);

    logic [CNT_W-1:0] cycle_cnt;

    always_ff @(posedge clock) begin
        if (rst || metro_clear) begin
            cycle_cnt  <= '0;
            beat_pulse <= 1'b0;
            beats      <= '0;
        end else begin
            beat_pulse <= 1'b0;
            if (metro_run) begin
                if (cycle_cnt == CNT_W'(BEAT_CYCLES - 1)) begin
                    cycle_cnt  <= '0;
                    beat_pulse <= 1'b1;
                    // Saturate so long notes never wrap
                    if (beats != 4'hF) begin
                        beats <= beats + 1'b1;
                    end
                end else begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                end
            end
        end
    end

    assign half_beat = (cycle_cnt >= CNT_W'(BEAT_CYCLES / 2));

endmodule

// ==== key_debouncer.sv ====
/*
 Per-bit debouncer. raw must already be synchronous to clock.
 A new level is accepted DEBOUNCE_TIME+1 cycles after it settles.
 DEBOUNCE_TIME must be at least 1.
*/
module key_debouncer #(
    parameter int WIDTH         = 13,
    parameter int DEBOUNCE_TIME = 4
) (
    input  logic             clock,
    input  logic             rst,
    input  logic [WIDTH-1:0] raw,
    output logic [WIDTH-1:0] stable
);

    localparam int CNT_W = $clog2(DEBOUNCE_TIME + 1);

    logic [CNT_W-1:0] cnt [WIDTH];

    always_ff @(posedge clock) begin
        if (rst) begin
            stable <= '0;
            for (int i = 0; i < WIDTH; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                // Any return to the accepted level restarts the wait
                if (raw[i] == stable[i]) begin
                    cnt[i] <= '0;
                end else if (cnt[i] == CNT_W'(DEBOUNCE_TIME)) begin
                    stable[i] <= raw[i];
                    cnt[i]    <= '0;
                end else begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

// ==== note_capture.sv ====
/*
 Encodes the debounced keys and registers the lowest pressed key.
 Only the press edge is captured, so holding a key does not re-arm it.
*/
module note_capture
    import piano_pkg::*;
(
    input  logic                clock,
    input  logic                rst,
    input  logic [num_keys-1:0] keys,
    input  logic                capture,
    input  logic                clear_note,
    output note_t               played_note,
    output logic                note_made
);

    note_t key_code;
    logic  made_q;
    logic  press_edge;

    // Lowest set key wins
    always_comb begin
        key_code = note_none;
        for (int i = num_keys - 1; i >= 0; i--) begin
            if (keys[i]) begin
                key_code = note_t'(i);
            end
        end
    end

    assign note_made  = |keys;
    assign press_edge = note_made & ~made_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            made_q      <= 1'b0;
            played_note <= note_none;
        end else begin
            made_q <= note_made;
            if (clear_note) begin
                played_note <= note_none;
            end else if (capture && press_edge) begin
                played_note <= key_code;
            end
        end
    end

endmodule

// ==== piano_datapath.sv ====
/*
 Piano trainer datapath. All control strobes come from an outside FSM.
 The song word at addr is valid one cycle after addr changes.
 SONG_DEPTH should be a power of two; counters wrap at SONG_DEPTH.
*/
module piano_datapath
    import piano_pkg::*, song_pkg::*;
#(
    parameter int CLOCK_FREQ    = 50_000_000,
    parameter int DEBOUNCE_TIME = 500_000,
    parameter int SONG_DEPTH    = 16,
    parameter int TIMEOUT_BEATS = 10
) (
    input  logic                clock,
    input  logic                rst,
    input  logic [num_keys-1:0] keys,
    input  logic                enter,
    input  logic                capture,
    input  logic                clear_note,
    input  logic                clear_addr,
    input  logic                step_addr,
    input  logic                clear_round,
    input  logic                step_round,
    input  logic                record,
    input  logic                metro_clear,
    input  logic                metro_run,
    input  logic                timer_clear,
    input  logic                timer_run,
    input  logic                show_song,
    input  logic                leds_on,
    input  logic                play,
    input  octave_t             octave,
    output logic                enter_pulse,
    output logic                note_made,
    output logic                note_ok,
    output logic                duration_ok,
    output logic                song_end,
    output logic                song_loop,
    output logic                addr_eq_round,
    output logic                timeout,
    output logic                beat_pulse,
    output logic [num_keys-1:0] leds,
    output logic                buzzer,
    output note_t               played_note,
    output note_t               song_note
);

    localparam int ADDR_W = $clog2(SONG_DEPTH);
    localparam int TO_W   = $clog2(TIMEOUT_BEATS + 1);

    logic [num_keys-1:0] keys_deb;
    logic                enter_deb;
    logic                enter_q;
    logic [ADDR_W-1:0]   addr;
    logic [ADDR_W-1:0]   round;
    logic [TO_W-1:0]     timeout_cnt;
    logic [3:0]          beats;
    song_word_t          rdata;
    song_word_t          wdata;
    note_t               shown_note;

    key_debouncer #(.WIDTH(num_keys), .DEBOUNCE_TIME(DEBOUNCE_TIME)) u_key_deb (
        .clock  (clock),
        .rst    (rst),
        .raw    (keys),
        .stable (keys_deb)
    );

    key_debouncer #(.WIDTH(1), .DEBOUNCE_TIME(DEBOUNCE_TIME)) u_enter_deb (
        .clock  (clock),
        .rst    (rst),
        .raw    (enter),
        .stable (enter_deb)
    );

    note_capture u_note_capture (
        .clock       (clock),
        .rst         (rst),
        .keys        (keys_deb),
        .capture     (capture),
        .clear_note  (clear_note),
        .played_note (played_note),
        .note_made   (note_made)
    );

    beat_metronome #(.CLOCK_FREQ(CLOCK_FREQ)) u_beat_metronome (
        .clock       (clock),
        .rst         (rst),
        .metro_clear (metro_clear),
        .metro_run   (metro_run),
        .beat_pulse  (beat_pulse),
        .half_beat   (),
        .beats       (beats)
    );

    // Recorded entries take the note just played and its length in beats
    assign wdata.note.note     = played_note;
    assign wdata.note.duration = beats;

    song_memory #(.SONG_DEPTH(SONG_DEPTH)) u_song_memory (
        .clock (clock),
        .addr  (addr),
        .write (record),
        .wdata (wdata),
        .rdata (rdata)
    );

    always_ff @(posedge clock) begin
        if (rst) begin
            enter_q     <= 1'b0;
            enter_pulse <= 1'b0;
            addr        <= '0;
            round       <= '0;
            timeout_cnt <= '0;
        end else begin
            enter_q     <= enter_deb;
            enter_pulse <= enter_deb & ~enter_q;

            if (clear_addr) begin
                addr <= '0;
            end else if (step_addr) begin
                addr <= addr + 1'b1;
            end

            if (clear_round) begin
                round <= '0;
            end else if (step_round) begin
                round <= round + 1'b1;
            end

            // Beats without a press, held once the limit is reached
            if (timer_clear) begin
                timeout_cnt <= '0;
            end else if (timer_run && beat_pulse && !timeout) begin
                timeout_cnt <= timeout_cnt + 1'b1;
            end
        end
    end

    assign timeout       = (timeout_cnt == TO_W'(TIMEOUT_BEATS));
    assign addr_eq_round = (round == addr);

    // Same word read both ways
    assign song_note   = rdata.note.note;
    assign note_ok     = (played_note == rdata.note.note);
    assign duration_ok = (beats == rdata.note.duration);
    assign song_end    = (rdata.ctrl.tag == end_tag);
    assign song_loop   = song_end && rdata.ctrl.flags[flag_loop];

    assign shown_note = show_song ? song_note : played_note;

    always_comb begin
        leds = '0;
        if (leds_on && (shown_note < num_keys)) begin
            leds = num_keys'(1) << shown_note;
        end
    end

    tone_generator u_tone_generator (
        .clock  (clock),
        .rst    (rst),
        .play   (play),
        .note   (shown_note),
        .octave (octave),
        .buzzer (buzzer)
    );

endmodule

// ==== piano_pkg.sv ====
/*
 Note codes and tone table shared by the piano trainer datapath.
 The half periods assume a 50 MHz clock and cover C4 up to C5.
 Codes 13 and 14 are unused and are treated like note_none.
*/
package piano_pkg;

    localparam int num_keys     = 13;
    localparam int octave_width = 2;
    localparam int div_width    = 17;

    typedef logic [3:0]              note_t;
    typedef logic [octave_width-1:0] octave_t;

    localparam note_t note_none = 4'd15;

    // Base half periods in clock cycles, key 0 is the lowest pitch
    localparam logic [div_width-1:0] note_divisor [num_keys] = '{
        17'd95556, 17'd90194, 17'd85132, 17'd80353,
        17'd75843, 17'd71586, 17'd67569, 17'd63776,
        17'd60197, 17'd56818, 17'd53630, 17'd50620,
        17'd47778
    };

endpackage

// ==== song.hex ====
// One byte per word: upper nibble is the note or tag, lower nibble the duration or flags
32
51
71
C3
02
F1
00
00
00
00
00
00
00
00
00
00

// ==== song_memory.sv ====
/*
 Single-port song RAM with a registered read, preloaded from song.hex.
 A write returns the old word on rdata in the same cycle.
 SONG_DEPTH should be a power of two.
*/
module song_memory
    import song_pkg::*;
#(
    parameter int SONG_DEPTH = 16
) (
    input  logic                          clock,
    input  logic [$clog2(SONG_DEPTH)-1:0] addr,
    input  logic                          write,
    input  song_word_t                    wdata,
    output song_word_t                    rdata
);

    song_word_t mem [SONG_DEPTH];

    initial begin
        $readmemh("song.hex", mem);
    end

    always_ff @(posedge clock) begin
        if (write) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// ==== song_pkg.sv ====
/*
 Song memory word layout. Each 8-bit word is either a note entry
 or a control entry; a tag of end_tag in the upper nibble marks control.
 Note fields are raw 4-bit codes so this package stands on its own.
*/
package song_pkg;

    typedef struct packed {
        logic [3:0] note;
        logic [3:0] duration;
    } note_entry_t;

    typedef struct packed {
        logic [3:0] tag;
        logic [3:0] flags;
    } ctrl_entry_t;

    typedef union packed {
        note_entry_t note;
        ctrl_entry_t ctrl;
    } song_word_t;

    localparam logic [3:0] end_tag = 4'hF;

    // Flags bit that restarts the song at address 0
    localparam int flag_loop = 0;

endpackage

// ==== tb.f ====
piano_pkg.sv
song_pkg.sv
key_debouncer.sv
note_capture.sv
beat_metronome.sv
tone_generator.sv
song_memory.sv
piano_datapath.sv
tb_piano_datapath.sv

// ==== tb_piano_datapath.sv ====
/*
 Testbench for the piano trainer datapath. Control strobes are driven
 here the way the outside FSM would drive them, always on the falling edge.
 Expects song.hex in the run directory. The tone check can take up to
 about 200k cycles for the lowest note at octave 0.
*/
module tb_piano_datapath
    import piano_pkg::*;
();

    localparam int CLOCK_FREQ    = 40;
    localparam int DEBOUNCE_TIME = 4;
    localparam int SONG_DEPTH    = 16;
    localparam int TIMEOUT_BEATS = 3;
    localparam int BEAT_CYCLES   = CLOCK_FREQ / 2;
    localparam int WAIT_LIMIT    = 400_000;

    // Copy of the song image in song.hex
    localparam logic [7:0] song_image [16] = '{
        8'h32, 8'h51, 8'h71, 8'hC3, 8'h02, 8'hF1, 8'h00, 8'h00,
        8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00
    };

    logic                clock;
    logic                rst;
    logic [num_keys-1:0] keys;
    logic                enter;
    logic                capture;
    logic                clear_note;
    logic                clear_addr;
    logic                step_addr;
    logic                clear_round;
    logic                step_round;
    logic                record;
    logic                metro_clear;
    logic                metro_run;
    logic                timer_clear;
    logic                timer_run;
    logic                show_song;
    logic                leds_on;
    logic                play;
    octave_t             octave;
    logic                enter_pulse;
    logic                note_made;
    logic                note_ok;
    logic                duration_ok;
    logic                song_end;
    logic                song_loop;
    logic                addr_eq_round;
    logic                timeout;
    logic                beat_pulse;
    logic [num_keys-1:0] leds;
    logic                buzzer;
    note_t               played_note;
    note_t               song_note;

    logic [31:0] lfsr = 32'ha4a51c44;
    int          key;
    int          other;
    int          glitch;
    int          cycles;
    int          pulses;
    int          exp_half;

    piano_datapath #(
        .CLOCK_FREQ    (CLOCK_FREQ),
        .DEBOUNCE_TIME (DEBOUNCE_TIME),
        .SONG_DEPTH    (SONG_DEPTH),
        .TIMEOUT_BEATS (TIMEOUT_BEATS)
    ) u_dut (
        .clock         (clock),
        .rst           (rst),
        .keys          (keys),
        .enter         (enter),
        .capture       (capture),
        .clear_note    (clear_note),
        .clear_addr    (clear_addr),
        .step_addr     (step_addr),
        .clear_round   (clear_round),
        .step_round    (step_round),
        .record        (record),
        .metro_clear   (metro_clear),
        .metro_run     (metro_run),
        .timer_clear   (timer_clear),
        .timer_run     (timer_run),
        .show_song     (show_song),
        .leds_on       (leds_on),
        .play          (play),
        .octave        (octave),
        .enter_pulse   (enter_pulse),
        .note_made     (note_made),
        .note_ok       (note_ok),
        .duration_ok   (duration_ok),
        .song_end      (song_end),
        .song_loop     (song_loop),
        .addr_eq_round (addr_eq_round),
        .timeout       (timeout),
        .beat_pulse    (beat_pulse),
        .leds          (leds),
        .buzzer        (buzzer),
        .played_note   (played_note),
        .song_note     (song_note)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        stop_run($sformatf("mismatch at %0t: %s", $time, msg));
    endtask

    task automatic report_timeout(input string what);
        stop_run($sformatf("Timed out at %0t while waiting for %s", $time, what));
    endtask

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
    function automatic int random_bits(input int n);
        logic fb;
        int   r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = (r << 1) | fb;
        end
        return r;
    endfunction

    function automatic logic [num_keys-1:0] onehot(input int k);
        logic [num_keys-1:0] v;
        v = '0;
        if (k < num_keys) begin
            v[k] = 1'b1;
        end
        return v;
    endfunction

    // Hold a key until it is debounced and captured, then release it
    task automatic press_key(input int k);
        int n;
        keys    = '0;
        keys[k] = 1'b1;
        n = 0;
        do begin
            @(negedge clock);
            n++;
            if (n > WAIT_LIMIT) report_timeout("a debounced key press");
        end while (note_made !== 1'b1);
        @(negedge clock);
        keys = '0;
        n = 0;
        do begin
            @(negedge clock);
            n++;
            if (n > WAIT_LIMIT) report_timeout("a debounced key release");
        end while (note_made !== 1'b0);
    endtask

    // Read word is valid on return
    task automatic goto_addr(input int a);
        clear_addr = 1'b1;
        @(negedge clock);
        clear_addr = 1'b0;
        step_addr  = 1'b1;
        repeat (a) @(negedge clock);
        step_addr = 1'b0;
        @(negedge clock);
    endtask

    task automatic step_address();
        step_addr = 1'b1;
        @(negedge clock);
        step_addr = 1'b0;
        @(negedge clock);
    endtask

    assert property (@(posedge clock) disable iff (rst) beat_pulse |=> !beat_pulse)
        else report_mismatch("beat_pulse lasted more than one cycle");

    assert property (@(posedge clock) disable iff (rst) song_loop |-> song_end)
        else report_mismatch("song_loop high without song_end");

    initial begin
        rst         = 1'b1;
        keys        = '0;
        enter       = 1'b0;
        capture     = 1'b1;
        clear_note  = 1'b0;
        clear_addr  = 1'b0;
        step_addr   = 1'b0;
        clear_round = 1'b0;
        step_round  = 1'b0;
        record      = 1'b0;
        metro_clear = 1'b0;
        metro_run   = 1'b0;
        timer_clear = 1'b0;
        timer_run   = 1'b0;
        show_song   = 1'b0;
        leds_on     = 1'b0;
        play        = 1'b0;
        octave      = '0;
        repeat (16) @(negedge clock);
        rst = 1'b0;
        @(negedge clock);
        assert (buzzer === 1'b0 && leds === '0 && enter_pulse === 1'b0 && beat_pulse === 1'b0
                && timeout === 1'b0 && played_note === note_none && addr_eq_round === 1'b1)
            else report_mismatch("outputs not at their reset values");
        assert (song_note === song_image[0][7:4])
            else report_mismatch($sformatf("song_note %0h at address 0", song_note));

        // Glitches shorter than the debounce time must be ignored
        key = random_bits(4) % num_keys;
        repeat (2) begin
            glitch  = random_bits(2) % (DEBOUNCE_TIME - 1) + 1;
            keys[key] = 1'b1;
            repeat (glitch) @(negedge clock);
            keys = '0;
            repeat (2) begin
                @(negedge clock);
                assert (note_made === 1'b0 && played_note === note_none)
                    else report_mismatch($sformatf("glitch of %0d cycles accepted", glitch));
            end
        end
        keys[key] = 1'b1;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > WAIT_LIMIT) report_timeout("note_made after a stable press");
        end while (note_made !== 1'b1);
        assert (cycles == DEBOUNCE_TIME + 1 && played_note === note_none)
            else report_mismatch($sformatf("press took %0d cycles, note %0d", cycles,
                                           played_note));
        @(negedge clock);
        assert (played_note === note_t'(key))
            else report_mismatch($sformatf("played_note %0d, expected %0d", played_note, key));
        keys = '0;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > WAIT_LIMIT) report_timeout("note_made to fall");
        end while (note_made !== 1'b0);
        assert (cycles == DEBOUNCE_TIME + 1 && played_note === note_t'(key))
            else report_mismatch($sformatf("release took %0d cycles", cycles));

        // Enter gives a single pulse one cycle after its debounced rise
        enter  = 1'b1;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > WAIT_LIMIT) report_timeout("enter_pulse");
        end while (enter_pulse !== 1'b1);
        assert (cycles == DEBOUNCE_TIME + 2)
            else report_mismatch($sformatf("enter_pulse after %0d cycles", cycles));
        @(negedge clock);
        assert (enter_pulse === 1'b0)
            else report_mismatch("enter_pulse lasted more than one cycle");
        enter = 1'b0;

        // Walk the song and play each expected note, then a wrong one
        goto_addr(0);
        for (int i = 0; i < 6; i++) begin
            if (i > 0) begin
                step_address();
            end
            if (i < 5) begin
                assert (song_note === song_image[i][7:4] && song_end === 1'b0)
                    else report_mismatch($sformatf("address %0d read note %0h", i, song_note));
                press_key(song_image[i][7:4]);
                assert (note_ok === 1'b1)
                    else report_mismatch($sformatf("note_ok low at address %0d", i));
                other = (song_image[i][7:4] + 1 + random_bits(4) % 12) % num_keys;
                press_key(other);
                assert (note_ok === 1'b0)
                    else report_mismatch($sformatf("note_ok high for key %0d", other));
            end
        end
        assert (song_end === 1'b1 && song_loop === 1'b1)
            else report_mismatch("end entry with loop not decoded at address 5");
        clear_round = 1'b1;
        @(negedge clock);
        clear_round = 1'b0;
        @(negedge clock);
        assert (addr_eq_round === 1'b0) else report_mismatch("addr_eq_round with round 0");
        step_round = 1'b1;
        repeat (5) @(negedge clock);
        step_round = 1'b0;
        assert (addr_eq_round === 1'b1) else report_mismatch("addr_eq_round low with round 5");
        step_round = 1'b1;
        @(negedge clock);
        step_round = 1'b0;
        assert (addr_eq_round === 1'b0) else report_mismatch("addr_eq_round high with round 6");

        // Beats until duration_ok at address 0
        goto_addr(0);
        metro_clear = 1'b1;
        @(negedge clock);
        metro_clear = 1'b0;
        metro_run   = 1'b1;
        pulses = 0;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (beat_pulse === 1'b1) pulses++;
            if (cycles > WAIT_LIMIT) report_timeout("duration_ok");
        end while (duration_ok !== 1'b1);
        assert (pulses == song_image[0][3:0])
            else report_mismatch($sformatf("duration_ok after %0d beats", pulses));
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > WAIT_LIMIT) report_timeout("beat_pulse");
        end while (beat_pulse !== 1'b1);
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > WAIT_LIMIT) report_timeout("the next beat_pulse");
        end while (beat_pulse !== 1'b1);
        assert (cycles == BEAT_CYCLES)
            else report_mismatch($sformatf("beat period %0d cycles", cycles));

        // Timeout counts beats seen after the clear
        timer_clear = 1'b1;
        timer_run   = 1'b1;
        @(negedge clock);
        timer_clear = 1'b0;
        assert (timeout === 1'b0) else report_mismatch("timeout high after timer_clear");
        pulses = 0;
        cycles = 0;
        while (timeout !== 1'b1) begin
            if (beat_pulse === 1'b1) pulses++;
            @(negedge clock);
            cycles++;
            if (cycles > WAIT_LIMIT) report_timeout("timeout");
        end
        assert (pulses == TIMEOUT_BEATS)
            else report_mismatch($sformatf("timeout after %0d beats", pulses));
        timer_run   = 1'b0;
        timer_clear = 1'b1;
        @(negedge clock);
        timer_clear = 1'b0;
        @(negedge clock);
        assert (timeout === 1'b0) else report_mismatch("timeout not cleared");

        // LEDs for the played note and the song note
        key = random_bits(4) % num_keys;
        press_key(key);
        leds_on = 1'b1;
        @(negedge clock);
        assert (leds === onehot(key)) else report_mismatch($sformatf("leds %b", leds));
        leds_on = 1'b0;
        @(negedge clock);
        assert (leds === '0) else report_mismatch($sformatf("leds %b while off", leds));
        goto_addr(3);
        show_song = 1'b1;
        leds_on   = 1'b1;
        @(negedge clock);
        assert (leds === onehot(song_image[3][7:4]))
            else report_mismatch($sformatf("song leds %b", leds));
        goto_addr(5);
        assert (leds === '0) else report_mismatch("leds lit for the end entry");
        show_song = 1'b0;
        leds_on   = 1'b0;

        // Buzzer half period from the tone table
        octave   = octave_t'(random_bits(2));
        exp_half = note_divisor[key] / (2 ** octave);
        @(negedge clock);
        play = 1'b1;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > WAIT_LIMIT) report_timeout("buzzer to rise");
        end while (buzzer !== 1'b1);
        assert (cycles == exp_half)
            else report_mismatch($sformatf("first half period %0d, expected %0d", cycles,
                                           exp_half));
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > WAIT_LIMIT) report_timeout("buzzer to fall");
        end while (buzzer !== 1'b0);
        assert (cycles == exp_half)
            else report_mismatch($sformatf("half period %0d, expected %0d", cycles, exp_half));
        play = 1'b0;
        @(negedge clock);
        assert (buzzer === 1'b0) else report_mismatch("buzzer high with play low");

        // Record a note at address 8 and read it back
        metro_run = 1'b0;
        key = random_bits(4) % num_keys;
        press_key(key);
        goto_addr(8);
        record = 1'b1;
        @(negedge clock);
        record = 1'b0;
        goto_addr(0);
        goto_addr(8);
        assert (song_note === note_t'(key) && duration_ok === 1'b1)
            else report_mismatch($sformatf("address 8 holds note %0d, expected %0d",
                                           song_note, key));

        // The played note returns to no note on clear_note
        clear_note = 1'b1;
        @(negedge clock);
        clear_note = 1'b0;
        assert (played_note === note_none)
            else report_mismatch($sformatf("played_note %0d after clear_note", played_note));

        $display("No errors");
        $finish;
    end

endmodule

// ==== tone_generator.sv ====
/*
 Square wave for the buzzer. Half period is the table entry shifted
 right by octave. Note codes outside the key range keep it silent.
 The counter is loaded while idle, so set the note before raising play.
*/
module tone_generator
    import piano_pkg::*;
(
    input  logic    clock,
    input  logic    rst,
    input  logic    play,
    input  note_t   note,
    input  octave_t octave,
    output logic    buzzer
);

    logic [div_width-1:0] half_period;
    logic [div_width-1:0] cnt;
    logic                 active;

    assign active = play && (note < num_keys);

    always_comb begin
        half_period = '0;
        if (note < num_keys) begin
            half_period = note_divisor[note] >> octave;
        end
    end

    always_ff @(posedge clock) begin
        if (rst || !active) begin
            cnt    <= half_period - 1'b1;
            buzzer <= 1'b0;
        end else if (cnt == '0) begin
            cnt    <= half_period - 1'b1;
            buzzer <= ~buzzer;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule
